//--- project.f
+incdir+include
rtl/mera_pkg.sv
rtl/panel_cmd_rx.sv
rtl/bus_master.sv
rtl/mem_elwro.sv
rtl/panel_resp_tx.sv
rtl/mera_sys.sv
bench/tb_mera_sys.sv

//--- Bender.yml
package:
  name: mera_sys

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - rtl/mera_pkg.sv
      - rtl/panel_cmd_rx.sv
      - rtl/bus_master.sv
      - rtl/mem_elwro.sv
      - rtl/panel_resp_tx.sv
      - rtl/mera_sys.sv
  - target: test
    include_dirs:
      - include
    files:
      - bench/tb_mera_sys.sv

//--- bench/tb_mera_sys.sv
`timescale 1ns/1ps
`default_nettype none

`include "mera_settings.svh"

module tb_mera_sys;

	import mera_pkg::*;

	// cycles any single wait may take before giving up
	localparam int WAIT_LIMIT = 1000;
	// address bits the memory decodes
	localparam logic [15:0] LOW_MASK = 16'((1 << `MEM_ADDR_W) - 1);

	logic        clk;
	logic        rst_n;
	logic        cmd_req;
	panel_cmd_t  cmd;
	logic        resp_ack;
	wire         cmd_ack;
	wire         resp_req;
	wire panel_resp_t resp;

	// reference memory keyed by block and low address
	logic [15:0]  model [int];
	int           written [$];
	panel_cmd_t   pending_cmds [$];
	panel_resp_t  expected [$];

	int value_errors;
	int proto_errors;
	int timeouts;
	bit hung;

	// handshake bookkeeping for the back-pressure check
	logic ack_q;
	logic req_q;
	int   n_acked;
	int   n_done;

	mera_sys dut_i (
		.clk(clk),
		.rst_n(rst_n),
		.cmd_req(cmd_req),
		.cmd(cmd),
		.cmd_ack(cmd_ack),
		.resp_req(resp_req),
		.resp(resp),
		.resp_ack(resp_ack)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// ----------------------------------------
	// model and stimulus helpers
	// ----------------------------------------

	// expected answer that also updates the model on stores
	function automatic panel_resp_t predict_response(input panel_cmd_t c);
		panel_resp_t r;
		int          key;
		key     = (int'(c.nb) << `MEM_ADDR_W) | int'(c.ad & LOW_MASK);
		r.op    = c.op;
		r.dt    = '0;
		r.alarm = 1'b0;
		if (int'(c.nb) >= `MEM_BLOCKS) begin
			// nobody answers for an absent block
			r.alarm = 1'b1;
		end else if (c.op == OP_STORE) begin
			model[key] = c.dt;
			written.push_back(key);
		end else if (model.exists(key)) begin
			r.dt = model[key];
		end
		return r;
	endfunction

	// mixed command where fetches only hit written words
	function automatic panel_cmd_t rand_cmd();
		panel_cmd_t c;
		int         pick;
		int         key;
		pick = $urandom_range(0, 9);
		c.dt = 16'($urandom);
		c.ad = 16'($urandom);
		if (pick == 0) begin
			c.op = panel_op_e'($urandom_range(0, 1));
			c.nb = 4'($urandom_range(`MEM_BLOCKS, 15));
		end else if (pick < 5 || written.size() == 0) begin
			// small low range so words get rewritten
			c.op = OP_STORE;
			c.nb = 4'($urandom_range(0, `MEM_BLOCKS - 1));
			c.ad = (c.ad & ~LOW_MASK) | 16'($urandom_range(0, 63));
		end else begin
			// random upper bits exercise aliasing
			key  = written[$urandom_range(0, written.size() - 1)];
			c.op = OP_FETCH;
			c.nb = 4'(key >> `MEM_ADDR_W);
			c.ad = (c.ad & ~LOW_MASK) | (16'(key) & LOW_MASK);
		end
		return c;
	endfunction

	task automatic queue_cmd(input panel_op_e op, input int nb, input logic [15:0] ad,
			input logic [15:0] dt);
		panel_cmd_t c;
		c.op = op;
		c.nb = 4'(nb);
		c.ad = ad;
		c.dt = dt;
		pending_cmds.push_back(c);
	endtask

	task automatic report_timeout(input string what);
		$display("timeout: %s after %0d cycles", what, WAIT_LIMIT);
		timeouts++;
		hung = 1'b1;
	endtask

	// ----------------------------------------
	// panel agent
	// ----------------------------------------

	// four-phase command exchange
	task automatic drive_cmd(input panel_cmd_t c);
		int cnt;
		if (hung) return;
		@(posedge clk);
		cmd     <= c;
		cmd_req <= 1'b1;
		cnt = 0;
		while (cmd_ack !== 1'b1 && cnt < WAIT_LIMIT) begin
			@(posedge clk);
			cnt++;
		end
		if (cnt >= WAIT_LIMIT) begin
			report_timeout("waiting for cmd_ack to rise");
			return;
		end
		cmd_req <= 1'b0;
		cnt = 0;
		while (cmd_ack !== 1'b0 && cnt < WAIT_LIMIT) begin
			@(posedge clk);
			cnt++;
		end
		if (cnt >= WAIT_LIMIT) report_timeout("waiting for cmd_ack to fall");
	endtask

	// four-phase result exchange with ack held back a random while
	task automatic take_resp(input int max_delay);
		panel_resp_t exp;
		int          cnt;
		int          dly;
		if (hung) return;
		cnt = 0;
		while (resp_req !== 1'b1 && cnt < WAIT_LIMIT) begin
			@(posedge clk);
			cnt++;
		end
		if (cnt >= WAIT_LIMIT) begin
			report_timeout("waiting for resp_req to rise");
			return;
		end
		assert (expected.size() != 0)
			else begin
				$display("response arrived with no command outstanding");
				proto_errors++;
			end
		if (expected.size() != 0) begin
			exp = expected.pop_front();
			assert (resp.op === exp.op)
				else begin
					$display("FAILED resp.op got %h expected %h", resp.op, exp.op);
					value_errors++;
				end
			assert (resp.dt === exp.dt)
				else begin
					$display("FAILED resp.dt got %h expected %h", resp.dt, exp.dt);
					value_errors++;
				end
			assert (resp.alarm === exp.alarm)
				else begin
					$display("FAILED resp.alarm got %h expected %h", resp.alarm, exp.alarm);
					value_errors++;
				end
		end
		dly = $urandom_range(0, max_delay);
		repeat (dly) @(posedge clk);
		@(posedge clk);
		resp_ack <= 1'b1;
		cnt = 0;
		while (resp_req !== 1'b0 && cnt < WAIT_LIMIT) begin
			@(posedge clk);
			cnt++;
		end
		if (cnt >= WAIT_LIMIT) report_timeout("waiting for resp_req to fall");
		resp_ack <= 1'b0;
	endtask

	// queued commands go first and random ones follow
	// results are collected alongside
	task automatic run_commands(input int n_random, input int max_delay);
		int total;
		total = pending_cmds.size() + n_random;
		fork
			begin
				panel_cmd_t c;
				for (int i = 0; i < total && !hung; i++) begin
					if (pending_cmds.size() > 0) c = pending_cmds.pop_front();
					else c = rand_cmd();
					expected.push_back(predict_response(c));
					drive_cmd(c);
				end
			end
			begin
				for (int j = 0; j < total && !hung; j++) begin
					take_resp(max_delay);
				end
			end
		join
	endtask

	// ----------------------------------------
	// back-pressure monitor
	// ----------------------------------------

	// buffer, master and sender hold at most three commands
	always @(posedge clk) begin
		if (!rst_n) begin
			ack_q   <= 1'b0;
			req_q   <= 1'b0;
			n_acked = 0;
			n_done  = 0;
		end else begin
			if (cmd_ack && !ack_q) begin
				n_acked++;
				assert (n_acked - n_done <= 3)
					else begin
						$display("cmd_ack rose while %0d commands were still in the design",
							n_acked - n_done - 1);
						proto_errors++;
					end
			end
			if (!resp_req && req_q) n_done++;
			ack_q <= cmd_ack;
			req_q <= resp_req;
		end
	end

	// ----------------------------------------
	// test sequence
	// ----------------------------------------
	initial begin
		logic [3:0]  nbs [8];
		logic [15:0] ads [8];
		void'($urandom(85));
		rst_n        = 1'b0;
		cmd_req      = 1'b0;
		cmd          = '0;
		resp_ack     = 1'b0;
		value_errors = 0;
		proto_errors = 0;
		timeouts     = 0;
		hung         = 1'b0;
		repeat (5) @(posedge clk);
		rst_n <= 1'b1;
		@(posedge clk);

		// idle ports after reset
		assert (cmd_ack === 1'b0)
			else begin
				$display("FAILED cmd_ack got %h expected 0", cmd_ack);
				value_errors++;
			end
		assert (resp_req === 1'b0)
			else begin
				$display("FAILED resp_req got %h expected 0", resp_req);
				value_errors++;
			end

		// stores to fitted blocks and read back
		for (int i = 0; i < 8; i++) begin
			nbs[i] = 4'($urandom_range(0, `MEM_BLOCKS - 1));
			ads[i] = 16'($urandom);
			queue_cmd(OP_STORE, nbs[i], ads[i], 16'($urandom));
		end
		for (int i = 0; i < 8; i++) queue_cmd(OP_FETCH, nbs[i], ads[i], '0);
		run_commands(0, 0);

		// upper address bits ignored while blocks stay apart
		queue_cmd(OP_STORE, 0, 16'h0155, 16'hA5C3);
		queue_cmd(OP_STORE, 1, 16'h0155, 16'h3C5A);
		queue_cmd(OP_FETCH, 0, 16'hFD55, '0);
		queue_cmd(OP_FETCH, 1, 16'h0155, '0);
		queue_cmd(OP_STORE, 0, 16'h8555, 16'h1234);
		queue_cmd(OP_FETCH, 0, 16'h0155, '0);
		queue_cmd(OP_FETCH, 1, 16'h0555, '0);
		run_commands(0, 0);

		// absent blocks alarm and leave memory alone
		queue_cmd(OP_STORE, 5, 16'h0155, 16'hDEAD);
		queue_cmd(OP_FETCH, 9, 16'h0155, '0);
		queue_cmd(OP_STORE, 15, 16'h0155, 16'hBEEF);
		queue_cmd(OP_FETCH, 0, 16'h0155, '0);
		queue_cmd(OP_FETCH, 1, 16'h0155, '0);
		run_commands(0, 0);

		// slow panel ack with the next request offered at once
		run_commands(40, 20);

		// long mixed run
		run_commands(300, 4);

		assert (expected.size() == 0)
			else begin
				$display("%0d responses never arrived", expected.size());
				proto_errors++;
			end

		$display("errors: %0d value, %0d protocol, %0d timeouts",
			value_errors, proto_errors, timeouts);
		if (value_errors == 0 && proto_errors == 0 && timeouts == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- rtl/mera_sys.sv
`timescale 1ns/1ps
`default_nettype none

module mera_sys (
	input  wire                        clk,
	input  wire                        rst_n,
	// panel command port
	input  wire                        cmd_req,
	input  wire mera_pkg::panel_cmd_t  cmd,
	output wire                        cmd_ack,
	// panel result port
	output wire                        resp_req,
	output wire mera_pkg::panel_resp_t resp,
	input  wire                        resp_ack
);

	import mera_pkg::*;

// ----------------------------------------
// --- PANEL COMMAND RECEIVER -------------
// ----------------------------------------

	wire             cmd_valid;
	wire             cmd_take;
	wire panel_cmd_t cmd_buf;

	panel_cmd_rx RX (
		.clk(clk),
		.rst_n(rst_n),
		.cmd_req(cmd_req),
		.cmd(cmd),
		.cmd_ack(cmd_ack),
		.cmd_valid(cmd_valid),
		.cmd_buf(cmd_buf),
		.cmd_take(cmd_take)
	);

// ----------------------------------------
// --- BUS MASTER -------------------------
// ----------------------------------------

	// system bus lines, active low
	wire        w_;
	wire        r_;
	wire        s_;
	wire        ok_;
	wire [3:0]  nb_;
	wire [15:0] ad_;
	wire [15:0] ddt_;
	wire [15:0] rdt_;
	// result towards the sender
	wire              resp_valid;
	wire              resp_ready;
	wire panel_resp_t mst_resp;

	bus_master MASTER (
		.clk(clk),
		.rst_n(rst_n),
		.cmd_valid(cmd_valid),
		.cmd_buf(cmd_buf),
		.cmd_take(cmd_take),
		.w_(w_),
		.r_(r_),
		.s_(s_),
		.nb_(nb_),
		.ad_(ad_),
		.ddt_(ddt_),
		.rdt_(rdt_),
		.ok_(ok_),
		.resp_valid(resp_valid),
		.resp(mst_resp),
		.resp_ready(resp_ready)
	);

// ----------------------------------------
// --- MEMORY -----------------------------
// ----------------------------------------

	mem_elwro MEM (
		.clk(clk),
		.rst_n(rst_n),
		.w_(w_),
		.r_(r_),
		.s_(s_),
		.nb_(nb_),
		.ad_(ad_),
		.ddt_(ddt_),
		.rdt_(rdt_),
		.ok_(ok_)
	);

// ----------------------------------------
// --- PANEL RESULT SENDER ----------------
// ----------------------------------------

	panel_resp_tx TX (
		.clk(clk),
		.rst_n(rst_n),
		.resp_valid(resp_valid),
		.resp(mst_resp),
		.resp_ready(resp_ready),
		.resp_req(resp_req),
		.resp_out(resp),
		.resp_ack(resp_ack)
	);

endmodule

`default_nettype wire

//--- rtl/panel_resp_tx.sv
`timescale 1ns/1ps
`default_nettype none

module panel_resp_tx (
	input  wire                        clk,
	input  wire                        rst_n,
	// from the bus master
	input  wire                        resp_valid,
	input  wire mera_pkg::panel_resp_t resp,
	output logic                       resp_ready,
	// four-phase port to the panel
	output logic                       resp_req,
	output mera_pkg::panel_resp_t      resp_out,
	input  wire                        resp_ack
);

	// handshake in progress
	logic busy;
	logic take;

	assign resp_ready = !busy;
	assign take       = resp_valid && !busy;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			busy     <= 1'b0;
			resp_req <= 1'b0;
		end else begin
			if (!busy) begin
				if (take) begin
					busy     <= 1'b1;
					resp_req <= 1'b1;
				end
			end else if (resp_req) begin
				// panel saw it, drop req
				if (resp_ack) begin
					resp_req <= 1'b0;
				end
			end else if (!resp_ack) begin
				// ack gone low, handshake done
				busy <= 1'b0;
			end
		end
	end

	// result held for the whole exchange
	always_ff @(posedge clk) begin
		if (take) begin
			resp_out <= resp;
		end
	end

	// panel may sample at any point while req is up
	assert property (@(posedge clk) disable iff (!rst_n)
		$past(resp_req) && resp_req |-> $stable(resp_out))
		else $error("resp_out changed while resp_req high");

endmodule

`default_nettype wire

//--- rtl/mem_elwro.sv
`timescale 1ns/1ps
`default_nettype none

`include "mera_settings.svh"

module mem_elwro (
	input  wire         clk,
	input  wire         rst_n,
	// system bus, all active low
	input  wire         w_,
	input  wire         r_,
	input  wire         s_,
	input  wire  [3:0]  nb_,
	input  wire  [15:0] ad_,
	input  wire  [15:0] ddt_,
	output logic [15:0] rdt_,
	output logic        ok_
);

	import mera_pkg::*;

	// block bits used in the word index
	localparam int BLK_W     = (`MEM_BLOCKS > 1) ? $clog2(`MEM_BLOCKS) : 1;
	localparam int IDX_W     = BLK_W + `MEM_ADDR_W;
	localparam int DLY_W     = $clog2(`MEM_DLY_TICKS + 1);
	// detect, last wait and access edges use three of the delay cycles
	localparam int WAIT_LOAD = `MEM_DLY_TICKS - 3;

	mem_state_e             state;
	logic [DLY_W-1:0]       cnt;
	logic [15:0]            words [2**IDX_W];
	logic [3:0]             nb;
	// upper address bits left unwired like the real module
	logic [`MEM_ADDR_W-1:0] ad;
	logic                   present;
	logic                   sel;
	logic [IDX_W-1:0]       idx;

	assign nb      = ~nb_;
	assign ad      = ~ad_[`MEM_ADDR_W-1:0];
	assign present = (int'(nb) < `MEM_BLOCKS);
	// strobe with a direction for a fitted block
	assign sel     = !s_ && (!w_ || !r_) && present;
	assign idx     = {nb[BLK_W-1:0], ad};

	// ----------------------------------------
	// answer sequence
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= MEM_IDLE;
			cnt   <= '0;
			ok_   <= 1'b1;
			rdt_  <= '1;
		end else begin
			case (state)
				MEM_IDLE: begin
					// absent blocks stay silent
					if (sel) begin
						cnt   <= DLY_W'(WAIT_LOAD);
						state <= MEM_WAIT;
					end
				end
				MEM_WAIT: begin
					if (s_) begin
						// master gave up
						state <= MEM_IDLE;
					end else if (cnt == '0) begin
						state <= MEM_OK;
					end else begin
						cnt <= cnt - 1'b1;
					end
				end
				MEM_OK: begin
					// read drives the inverted word
					// writes go through the store path below
					if (!r_) begin
						rdt_ <= ~words[idx];
					end
					ok_   <= 1'b0;
					state <= MEM_HOLD;
				end
				MEM_HOLD: begin
					// keep ok_ until the strobe goes away
					if (s_) begin
						ok_   <= 1'b1;
						rdt_  <= '1;
						state <= MEM_IDLE;
					end
				end
				default: state <= MEM_IDLE;
			endcase
		end
	end

	// store path into the word array
	always_ff @(posedge clk) begin
		if ((state == MEM_OK) && !w_) begin
			words[idx] <= ~ddt_;
		end
	end

	// ok_ only ever answers a live strobe
	assert property (@(posedge clk) disable iff (!rst_n) $fell(ok_) |-> !s_)
		else $error("ok_ fell while s_ was high");

endmodule

`default_nettype wire

//--- rtl/bus_master.sv
`timescale 1ns/1ps
`default_nettype none

`include "mera_settings.svh"

module bus_master (
	input  wire                       clk,
	input  wire                       rst_n,
	// from the command receiver
	input  wire                       cmd_valid,
	input  wire mera_pkg::panel_cmd_t cmd_buf,
	output logic                      cmd_take,
	// system bus, all active low
	output logic                      w_,
	output logic                      r_,
	output logic                      s_,
	output logic [3:0]                nb_,
	output logic [15:0]               ad_,
	output logic [15:0]               ddt_,
	input  wire  [15:0]               rdt_,
	input  wire                       ok_,
	// to the response sender
	output logic                      resp_valid,
	output mera_pkg::panel_resp_t     resp,
	input  wire                       resp_ready
);

	import mera_pkg::*;

	// timeout counter, loaded with ALARM_TICKS-1
	localparam int TMR_W = $clog2(`ALARM_TICKS + 1);

	bus_state_e       state;
	logic [TMR_W-1:0] tmr;
	// last strobe cycle without ok_
	logic             tmo;

	// accept only from idle, s_ follows one cycle later
	assign cmd_take   = (state == BUS_IDLE) && cmd_valid;
	assign resp_valid = (state == BUS_REPLY) && resp_ready;
	assign tmo        = (state == BUS_STROBE) && (tmr == '0);

	// ----------------------------------------
	// bus cycle FSM
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= BUS_IDLE;
			tmr   <= '0;
			w_    <= 1'b1;
			r_    <= 1'b1;
			s_    <= 1'b1;
			nb_   <= '1;
			ad_   <= '1;
			ddt_  <= '1;
		end else begin
			case (state)
				BUS_IDLE: begin
					if (cmd_take) begin
						// inverted values onto the lines
						w_    <= (cmd_buf.op != OP_STORE);
						r_    <= (cmd_buf.op != OP_FETCH);
						s_    <= 1'b0;
						nb_   <= ~cmd_buf.nb;
						ad_   <= ~cmd_buf.ad;
						ddt_  <= ~cmd_buf.dt;
						tmr   <= TMR_W'(`ALARM_TICKS - 1);
						state <= BUS_STROBE;
					end
				end
				BUS_STROBE: begin
					if (!ok_ || tmo) begin
						// memory answered or nobody home
						w_    <= 1'b1;
						r_    <= 1'b1;
						s_    <= 1'b1;
						nb_   <= '1;
						ad_   <= '1;
						ddt_  <= '1;
						state <= BUS_RELEASE;
					end else begin
						tmr <= tmr - 1'b1;
					end
				end
				BUS_RELEASE: begin
					// memory lets go of ok_ after s_ rises
					if (ok_) begin
						state <= BUS_REPLY;
					end
				end
				BUS_REPLY: begin
					if (resp_valid) begin
						state <= BUS_IDLE;
					end
				end
				default: state <= BUS_IDLE;
			endcase
		end
	end

	// result payload
	always_ff @(posedge clk) begin
		if (cmd_take) begin
			resp.op <= cmd_buf.op;
		end
		if ((state == BUS_STROBE) && !ok_) begin
			// un-invert the read lines, stores return zero
			resp.dt    <= (resp.op == OP_FETCH) ? ~rdt_ : '0;
			resp.alarm <= 1'b0;
		end else if (tmo) begin
			resp.dt    <= '0;
			resp.alarm <= 1'b1;
		end
	end

	// one direction per bus cycle
	assert property (@(posedge clk) disable iff (!rst_n) !(!w_ && !r_))
		else $error("w_ and r_ low together");

	// strobe ends only on ok_ or on timeout
	assert property (@(posedge clk) disable iff (!rst_n)
		$past(rst_n) && $rose(s_) |-> $past(!ok_ || tmo))
		else $error("s_ released without ok_ or timeout");

endmodule

`default_nettype wire

//--- rtl/panel_cmd_rx.sv
`timescale 1ns/1ps
`default_nettype none

module panel_cmd_rx (
	input  wire                       clk,
	input  wire                       rst_n,
	// four-phase port from the panel
	input  wire                       cmd_req,
	input  wire mera_pkg::panel_cmd_t cmd,
	output logic                      cmd_ack,
	// one-entry buffer towards the bus master
	output logic                      cmd_valid,
	output mera_pkg::panel_cmd_t      cmd_buf,
	input  wire                       cmd_take
);

	// new request, ack phase idle and buffer empty
	logic load;

	assign load = cmd_req && !cmd_ack && !cmd_valid;

	// ack phase and buffer occupancy, tracked apart
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			cmd_ack   <= 1'b0;
			cmd_valid <= 1'b0;
		end else begin
			if (load) begin
				// ack and fill on the same edge
				cmd_ack   <= 1'b1;
				cmd_valid <= 1'b1;
			end else begin
				// panel dropped req, finish the handshake
				if (cmd_ack && !cmd_req) begin
					cmd_ack <= 1'b0;
				end
				// master took the command
				if (cmd_take) begin
					cmd_valid <= 1'b0;
				end
			end
		end
	end

	// command payload, held until the next load
	always_ff @(posedge clk) begin
		if (load) begin
			cmd_buf <= cmd;
		end
	end

	// master only takes from a full buffer
	assert property (@(posedge clk) disable iff (!rst_n) cmd_take |-> cmd_valid)
		else $error("cmd_take seen with empty command buffer");

endmodule

`default_nettype wire

//--- rtl/mera_pkg.sv
`default_nettype none

package mera_pkg;

	// ----------------------------------------
	// panel side
	// ----------------------------------------

	// panel command kind
	typedef enum logic {
		OP_FETCH,
		OP_STORE
	} panel_op_e;

	// one panel command, 37 bits
	typedef struct packed {
		panel_op_e   op;
		// block number
		logic [3:0]  nb;
		// word address, upper bits ignored by memory
		logic [15:0] ad;
		// store data
		logic [15:0] dt;
	} panel_cmd_t;

	// one result back to the panel, 18 bits
	typedef struct packed {
		// echoed from the command
		panel_op_e   op;
		// fetched word, zero for store or alarm
		logic [15:0] dt;
		// no memory answered
		logic        alarm;
	} panel_resp_t;

	// ----------------------------------------
	// bus side
	// ----------------------------------------

	// bus master cycle
	typedef enum logic [1:0] {
		BUS_IDLE,
		BUS_STROBE,
		BUS_RELEASE,
		BUS_REPLY
	} bus_state_e;

	// memory answer sequence
	typedef enum logic [1:0] {
		MEM_IDLE,
		MEM_WAIT,
		MEM_OK,
		MEM_HOLD
	} mem_state_e;

endpackage

`default_nettype wire

//--- include/mera_settings.svh
`ifndef MERA_SETTINGS_SVH
`define MERA_SETTINGS_SVH

// memory geometry
// address bits decoded inside one block, 1024 words
`define MEM_ADDR_W 10

// blocks fitted on the memory module
// blocks from here up to 15 never answer
`define MEM_BLOCKS 2

// bus timing, in clk cycles
// strobe seen low -> ok_ pulled low, at least 3
`define MEM_DLY_TICKS 3

// master wait for ok_ before giving up
// alarm on missing memory, as on the real CPU
`define ALARM_TICKS 15

`endif
